//--- proc.f
hw/proc_pkg.sv
hw/pipe_reg.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/memory.sv
hw/hazard_unit.sv
hw/proc.sv
verification/proc_assertions.sv
verification/proc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module proc_tb -f proc.f -o proc_sim
./obj_dir/proc_sim 2>&1 | tee sim.log || true

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
    exit 1
fi
grep -q "\*\*\* PASSED \*\*\*" sim.log

//--- verification/proc_tb.sv
`timescale 1ns/1ns

module proc_tb;

    import proc_pkg::*;

    localparam int NPROG = 5;
    localparam int MAX_EXP = 8;
    localparam int RUN_TIMEOUT = 800;

    logic            clk;
    logic            rst_n;
    logic            irq;
    logic [XLEN-1:0] irq_data;
    logic            credit_return;
    logic            imem_we;
    logic [5:0]      imem_addr;
    logic [XLEN-1:0] imem_wdata;
    logic            send_valid;
    logic [XLEN-1:0] send_data;

    // Program table: image, expected sends, credit delay, irq cycle, irq word
    logic [31:0] prog_mem [NPROG][IMEM_DEPTH];
    logic [31:0] exp_val [NPROG][MAX_EXP];
    int          n_exp [NPROG];
    int          credit_delay [NPROG];
    int          irq_at [NPROG];
    logic [31:0] irq_word [NPROG];

    int          cur;
    int          wp;
    int          got_cnt;
    int          handler_cnt;
    int          sends_total;
    int          returned_total;
    int          cycle;
    int          pending [$];
    logic [31:0] lcg_state = 32'h2b3e;

    proc dut0 (
        .clk(clk), .rst_n(rst_n), .irq(irq), .irq_data(irq_data),
        .credit_return(credit_return), .imem_we(imem_we), .imem_addr(imem_addr),
        .imem_wdata(imem_wdata), .send_valid(send_valid), .send_data(send_data)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // RV32I instruction formats
    function automatic logic [31:0] itype(logic [6:0] opc, logic [2:0] f3, int rd, int rs1,
                                          int imm);
        logic [11:0] i;
        i = imm[11:0];
        return {i, rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] rtype(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                          int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
    endfunction

    function automatic logic [31:0] utype(int rd, logic [19:0] imm);
        return {imm, rd[4:0], OP_LUI};
    endfunction

    function automatic logic [31:0] stype(int rs2, int rs1, int imm);
        logic [11:0] i;
        i = imm[11:0];
        return {i[11:5], rs2[4:0], rs1[4:0], 3'b010, i[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] btype(logic [2:0] f3, int rs1, int rs2, int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2[4:0], rs1[4:0], f3, o[4:1], o[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] jtype(int rd, int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], rd[4:0], OP_JAL};
    endfunction

    function automatic logic [31:0] snd_word(int rs1);
        return {12'b0, rs1[4:0], 3'b0, 5'b0, OP_SND};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog_mem[cur][wp] = w;
        wp++;
    endtask

    task automatic expect_send(input logic [31:0] v);
        exp_val[cur][n_exp[cur]] = v;
        n_exp[cur]++;
    endtask

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_fail("Value check failed");
        end
    endtask

    task automatic build_programs();
        for (int p = 0; p < NPROG; p++) begin
            for (int a = 0; a < IMEM_DEPTH; a++) begin
                prog_mem[p][a] = '0;
            end
            n_exp[p] = 0;
            credit_delay[p] = 0;
            irq_at[p] = 0;
            irq_word[p] = '0;
        end
        // ALU chain, each result used by the next instruction
        cur = 0;
        wp = 0;
        emit(utype(1, 20'h12345));
        emit(itype(OP_IMM, 3'b000, 1, 1, 'h678));
        emit(itype(OP_IMM, 3'b000, 2, 1, -1));
        emit(rtype(7'b0100000, 3'b000, 3, 1, 2));
        emit(rtype(7'b0, 3'b100, 4, 1, 3));
        emit(snd_word(4));
        emit(rtype(7'b0, 3'b111, 5, 4, 2));
        emit(rtype(7'b0, 3'b110, 6, 5, 3));
        emit(rtype(7'b0, 3'b000, 7, 6, 6));
        emit(snd_word(7));
        emit(snd_word(3));
        emit(jtype(0, 0));
        expect_send(32'h12345679);
        expect_send(32'h2468ace2);
        expect_send(32'h00000001);
        // Store, load, then immediate use
        cur = 1;
        wp = 0;
        emit(itype(OP_IMM, 3'b000, 1, 0, 16));
        emit(utype(2, 20'hcafeb));
        emit(itype(OP_IMM, 3'b000, 2, 2, 'h0ee));
        emit(stype(2, 1, 4));
        emit(itype(OP_LOAD, 3'b010, 3, 1, 4));
        emit(rtype(7'b0, 3'b000, 4, 3, 1));
        emit(snd_word(4));
        emit(itype(OP_LOAD, 3'b010, 5, 1, 4));
        emit(snd_word(5));
        emit(jtype(0, 0));
        expect_send(32'hcafeb0fe);
        expect_send(32'hcafeb0ee);
        // BNE loop, JAL skip and taken BEQ
        cur = 2;
        wp = 0;
        emit(itype(OP_IMM, 3'b000, 1, 0, 0));
        emit(itype(OP_IMM, 3'b000, 2, 0, 3));
        emit(itype(OP_IMM, 3'b000, 1, 1, 1));
        emit(snd_word(1));
        emit(btype(3'b001, 1, 2, -8));
        emit(jtype(0, 12));
        emit(itype(OP_IMM, 3'b000, 9, 0, 'h77));
        emit(snd_word(9));
        emit(itype(OP_IMM, 3'b000, 3, 0, 'h55));
        emit(btype(3'b000, 3, 3, 8));
        emit(snd_word(3));
        emit(snd_word(2));
        emit(jtype(0, 0));
        for (int v = 1; v <= 3; v++) begin
            expect_send(v);
        end
        expect_send(32'd3);
        // Five sends against slow credit returns
        cur = 3;
        wp = 0;
        emit(itype(OP_IMM, 3'b000, 1, 0, 'h11));
        for (int k = 0; k < 5; k++) begin
            emit(snd_word(1));
            emit(itype(OP_IMM, 3'b000, 1, 1, 1));
            expect_send(32'h11 + k);
        end
        emit(jtype(0, 0));
        credit_delay[3] = 30;
        // Counting loop with an interrupt handler at word 32
        cur = 4;
        wp = 0;
        emit(itype(OP_IMM, 3'b000, 1, 0, 0));
        emit(itype(OP_IMM, 3'b000, 2, 0, 5));
        emit(itype(OP_IMM, 3'b000, 1, 1, 1));
        emit(snd_word(1));
        emit(btype(3'b001, 1, 2, -8));
        emit(jtype(0, 0));
        for (int v = 1; v <= 5; v++) begin
            expect_send(v);
        end
        wp = INT_VECTOR / 4;
        emit({20'b0, 5'd5, OP_RDI});
        emit(snd_word(5));
        emit(itype(OP_IMM, 3'b000, 0, 0, 0));
        emit(itype(OP_IMM, 3'b000, 0, 0, 0));
        emit({25'b0, OP_RTI});
        irq_at[4] = 12;
        irq_word[4] = 32'hdead0001;
    endtask

    // Device model: credit returns, interrupt line
    always @(posedge clk) begin
        if (!rst_n) begin
            cycle <= 0;
            credit_return <= 1'b0;
            irq <= 1'b0;
            returned_total <= 0;
            pending.delete();
        end else begin
            cycle <= cycle + 1;
            credit_return <= 1'b0;
            if (pending.size() > 0 && pending[0] <= cycle) begin
                credit_return <= 1'b1;
                returned_total <= returned_total + 1;
                void'(pending.pop_front());
            end
            if (handler_cnt > 0) begin
                irq <= 1'b0;
            end else if (irq_at[cur] != 0 && cycle == irq_at[cur]) begin
                irq <= 1'b1;
            end
        end
    end

    // Send monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            got_cnt = 0;
            handler_cnt = 0;
            sends_total = 0;
        end else if (send_valid) begin
            sends_total++;
            check_value("credit_overrun", (sends_total - returned_total) > SEND_CREDITS, 0);
            if (credit_delay[cur] > 0) begin
                pending.push_back(cycle + credit_delay[cur] + int'(next_rand() % 8));
            end else begin
                pending.push_back(cycle + 1);
            end
            if (irq_at[cur] != 0 && send_data == irq_data) begin
                handler_cnt++;
            end else if (got_cnt >= n_exp[cur]) begin
                stop_fail($sformatf("Unexpected extra send %h in program %0d", send_data, cur));
            end else begin
                check_value("send_data", send_data, exp_val[cur][got_cnt]);
                got_cnt++;
            end
        end
    end

    initial begin
        int timeout;

        clk = 1'b0;
        rst_n = 1'b0;
        irq = 1'b0;
        irq_data = '0;
        credit_return = 1'b0;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_wdata = '0;
        build_programs();
        for (int p = 0; p < NPROG; p++) begin
            @(posedge clk);
            rst_n <= 1'b0;
            irq_data <= irq_word[p];
            for (int a = 0; a < IMEM_DEPTH; a++) begin
                @(posedge clk);
                imem_we <= 1'b1;
                imem_addr <= a[5:0];
                imem_wdata <= prog_mem[p][a];
            end
            @(posedge clk);
            imem_we <= 1'b0;
            cur = p;
            repeat (4) @(posedge clk);
            rst_n <= 1'b1;
            timeout = 0;
            while (got_cnt < n_exp[p] || (irq_at[p] != 0 && handler_cnt == 0)) begin
                @(posedge clk);
                timeout++;
                if (timeout > RUN_TIMEOUT) begin
                    stop_fail($sformatf("Timeout waiting for sends in program %0d", p));
                end
            end
            // Flushed instructions must stay silent
            timeout = 0;
            while (timeout < 40) begin
                @(posedge clk);
                timeout++;
            end
            if (irq_at[p] != 0) begin
                check_value("handler_sends", handler_cnt, 1);
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- verification/proc_assertions.sv
`timescale 1ns/1ns

module proc_assertions (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          stall,
    input logic                          flush,
    input logic                          irq_take,
    input logic                          rti_exec,
    input logic                          snd_in_ex,
    input logic                          credit_return,
    input logic [proc_pkg::CREDIT_W-1:0] credit_cnt
);

    import proc_pkg::*;

    int   in_flight;
    logic in_handler;

    // SNDs past decode that the device has not paid back yet
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(snd_in_ex) - int'(credit_return);
        end
    end

    // Set from a taken interrupt until its RTI executes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_handler <= 1'b0;
        end else if (rti_exec) begin
            in_handler <= 1'b0;
        end else if (irq_take) begin
            in_handler <= 1'b1;
        end
    end

    sends_within_credit: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight <= SEND_CREDITS) else $error("More sends in flight than device credits");

    credit_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= SEND_CREDITS) else $error("Credit counter out of range");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !flush && !stall) else $error("Stall or flush right after reset");

    no_nested_irq: assert property (@(posedge clk) disable iff (!rst_n)
        in_handler |-> !irq_take) else $error("Interrupt taken before RTI of the last one");

endmodule

bind hazard_unit proc_assertions u_checks (
    .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .irq_take(irq_take),
    .rti_exec(rti_exec), .snd_in_ex(id_ex.snd), .credit_return(credit_return),
    .credit_cnt(credit_cnt)
);

//--- hw/proc.sv
`timescale 1ns/1ns

module proc (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      irq,
    input  logic [proc_pkg::XLEN-1:0] irq_data,
    input  logic                      credit_return,
    input  logic                      imem_we,
    input  logic [5:0]                imem_addr,
    input  logic [proc_pkg::XLEN-1:0] imem_wdata,
    output logic                      send_valid,
    output logic [proc_pkg::XLEN-1:0] send_data
);

    import proc_pkg::*;

    if_id_t   if_id_d, if_id_q;
    id_ex_t   id_ex_d, id_ex_q;
    ex_mem_t  ex_mem_d, ex_mem_q;
    mem_wb_t  mem_wb_d, mem_wb_q;

    logic            stall;
    logic            flush;
    logic            irq_take;
    logic            redirect;
    logic            rti_exec;
    logic [XLEN-1:0] redirect_pc;
    logic [XLEN-1:0] epc;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] ex_mem_fwd;
    fwd_sel_e        fwd_a, fwd_b;

    // Writeback select, also reused for the EX/MEM forward path
    assign wb_data    = wb_value(mem_wb_q);
    assign ex_mem_fwd = wb_value(mem_wb_d);

    fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .stall(stall), .irq_take(irq_take),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .if_id(if_id_d)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
        .d(if_id_d), .q(if_id_q)
    );

    decode u_decode (
        .clk(clk), .rst_n(rst_n), .irq_take(irq_take), .if_id(if_id_q),
        .wb_we(mem_wb_q.reg_write), .wb_rd(mem_wb_q.rd), .wb_data(wb_data),
        .id_ex(id_ex_d), .epc(epc)
    );

    // A decode stall leaves a bubble in execute
    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(flush | stall),
        .d(id_ex_d), .q(id_ex_q)
    );

    execute u_execute (
        .id_ex(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .ex_mem_fwd(ex_mem_fwd), .wb_fwd(wb_data), .epc(epc),
        .ex_mem(ex_mem_d), .redirect(redirect), .redirect_pc(redirect_pc),
        .rti_exec(rti_exec)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    memory u_memory (
        .clk(clk), .ex_mem(ex_mem_q), .irq_data(irq_data), .mem_wb(mem_wb_d),
        .send_valid(send_valid), .send_data(send_data)
    );

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    hazard_unit u_hazard (
        .clk(clk), .rst_n(rst_n),
        .if_id(if_id_q), .id_ex(id_ex_q), .ex_mem(ex_mem_q), .mem_wb(mem_wb_q),
        .redirect(redirect), .rti_exec(rti_exec), .irq(irq),
        .credit_return(credit_return),
        .stall(stall), .flush(flush), .irq_take(irq_take),
        .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

endmodule

//--- hw/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  proc_pkg::if_id_t    if_id,
    input  proc_pkg::id_ex_t    id_ex,
    input  proc_pkg::ex_mem_t   ex_mem,
    input  proc_pkg::mem_wb_t   mem_wb,
    input  logic                redirect,
    input  logic                rti_exec,
    input  logic                irq,
    input  logic                credit_return,
    output logic                stall,
    output logic                flush,
    output logic                irq_take,
    output proc_pkg::fwd_sel_e  fwd_a,
    output proc_pkg::fwd_sel_e  fwd_b
);

    import proc_pkg::*;

    logic [CREDIT_W-1:0] credit_cnt;
    logic                irq_latch;
    logic [4:0]          dec_rs1;
    logic [4:0]          dec_rs2;
    logic                dec_snd;
    logic                load_use;
    logic                snd_block;
    logic                snd_issue;

    function automatic fwd_sel_e fwd_pick(logic [4:0] rs);
        if (ex_mem.reg_write && ex_mem.rd != 5'd0 && ex_mem.rd == rs) begin
            return FWD_EXMEM;
        end else if (mem_wb.reg_write && mem_wb.rd != 5'd0 && mem_wb.rd == rs) begin
            return FWD_MEMWB;
        end
        return FWD_RF;
    endfunction

    assign fwd_a = fwd_pick(id_ex.rs1);
    assign fwd_b = fwd_pick(id_ex.rs2);

    assign dec_rs1 = if_id.instr[19:15];
    assign dec_rs2 = if_id.instr[24:20];
    assign dec_snd = (if_id.instr[6:0] == OP_SND);

    assign load_use  = id_ex.mem_read && id_ex.rd != 5'd0 &&
                       (id_ex.rd == dec_rs1 || id_ex.rd == dec_rs2);
    assign snd_block = dec_snd && credit_cnt == '0;
    assign stall     = load_use || snd_block;

    // Only a non-bubble in decode can be the return point
    assign irq_take  = irq && !irq_latch && !stall && !redirect && if_id.instr != '0;
    assign flush     = redirect || irq_take;
    assign snd_issue = dec_snd && !stall && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CREDIT_W'(SEND_CREDITS);
        end else if (snd_issue && !credit_return) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (credit_return && !snd_issue) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    // No nesting until RTI reaches execute
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_latch <= 1'b0;
        end else if (rti_exec) begin
            irq_latch <= 1'b0;
        end else if (irq_take) begin
            irq_latch <= 1'b1;
        end
    end

endmodule

//--- hw/memory.sv
`timescale 1ns/1ns

module memory (
    input  logic                      clk,
    input  proc_pkg::ex_mem_t         ex_mem,
    input  logic [proc_pkg::XLEN-1:0] irq_data,
    output proc_pkg::mem_wb_t         mem_wb,
    output logic                      send_valid,
    output logic [proc_pkg::XLEN-1:0] send_data
);

    import proc_pkg::*;

    logic [XLEN-1:0]    dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] word_idx;

    // Word addressed, low two bits ignored
    assign word_idx = ex_mem.alu_result[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (ex_mem.mem_write) begin
            dmem[word_idx] <= ex_mem.store_data;
        end
    end

    assign mem_wb.alu_result = ex_mem.alu_result;
    assign mem_wb.load_data  = ex_mem.mem_read ? dmem[word_idx] : '0;
    assign mem_wb.pc4        = ex_mem.pc4;
    assign mem_wb.rdi_data   = ex_mem.rdi ? irq_data : '0;
    assign mem_wb.rd         = ex_mem.rd;
    assign mem_wb.wb_sel     = ex_mem.wb_sel;
    assign mem_wb.reg_write  = ex_mem.reg_write;

    // One pulse per SND since EX/MEM never holds
    assign send_valid = ex_mem.snd;
    assign send_data  = ex_mem.alu_result;

endmodule

//--- hw/execute.sv
`timescale 1ns/1ns

module execute (
    input  proc_pkg::id_ex_t          id_ex,
    input  proc_pkg::fwd_sel_e        fwd_a,
    input  proc_pkg::fwd_sel_e        fwd_b,
    input  logic [proc_pkg::XLEN-1:0] ex_mem_fwd,
    input  logic [proc_pkg::XLEN-1:0] wb_fwd,
    input  logic [proc_pkg::XLEN-1:0] epc,
    output proc_pkg::ex_mem_t         ex_mem,
    output logic                      redirect,
    output logic [proc_pkg::XLEN-1:0] redirect_pc,
    output logic                      rti_exec
);

    import proc_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_y;
    logic            taken;

    always_comb begin
        case (fwd_a)
            FWD_EXMEM: op_a = ex_mem_fwd;
            FWD_MEMWB: op_a = wb_fwd;
            default:   op_a = id_ex.rs1_data;
        endcase
        case (fwd_b)
            FWD_EXMEM: op_b = ex_mem_fwd;
            FWD_MEMWB: op_b = wb_fwd;
            default:   op_b = id_ex.rs2_data;
        endcase
    end

    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB:    alu_y = op_a - alu_b;
            ALU_AND:    alu_y = op_a & alu_b;
            ALU_OR:     alu_y = op_a | alu_b;
            ALU_XOR:    alu_y = op_a ^ alu_b;
            ALU_PASS_B: alu_y = alu_b;
            default:    alu_y = op_a + alu_b;
        endcase
    end

    // BNE inverts the equality test
    assign taken       = id_ex.branch && ((op_a == op_b) != id_ex.branch_ne);
    assign rti_exec    = id_ex.rti;
    assign redirect    = taken || id_ex.jal || id_ex.rti;
    assign redirect_pc = id_ex.rti ? epc : id_ex.pc + id_ex.imm;

    always_comb begin
        ex_mem            = '0;
        ex_mem.pc4        = id_ex.pc + 32'd4;
        ex_mem.alu_result = alu_y;
        ex_mem.store_data = op_b;
        ex_mem.rd         = id_ex.rd;
        ex_mem.wb_sel     = id_ex.wb_sel;
        ex_mem.reg_write  = id_ex.reg_write;
        ex_mem.mem_read   = id_ex.mem_read;
        ex_mem.mem_write  = id_ex.mem_write;
        ex_mem.snd        = id_ex.snd;
        ex_mem.rdi        = id_ex.rdi;
    end

endmodule

//--- hw/decode.sv
`timescale 1ns/1ns

module decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      irq_take,
    input  proc_pkg::if_id_t          if_id,
    input  logic                      wb_we,
    input  logic [4:0]                wb_rd,
    input  logic [proc_pkg::XLEN-1:0] wb_data,
    output proc_pkg::id_ex_t          id_ex,
    output logic [proc_pkg::XLEN-1:0] epc
);

    import proc_pkg::*;

    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] ins;
    logic [6:0]      opcode;
    logic [2:0]      funct3;

    assign ins    = if_id.instr;
    assign opcode = ins[6:0];
    assign funct3 = ins[14:12];

    // Write in the same cycle shows up on the read
    function automatic logic [XLEN-1:0] rf_read(logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end else if (wb_we && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Return address is the instruction being flushed from decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            epc <= '0;
        end else if (irq_take) begin
            epc <= if_id.pc;
        end
    end

    always_comb begin
        id_ex          = '0;
        id_ex.pc       = if_id.pc;
        id_ex.rs1      = ins[19:15];
        id_ex.rs2      = ins[24:20];
        id_ex.rd       = ins[11:7];
        id_ex.rs1_data = rf_read(ins[19:15]);
        id_ex.rs2_data = rf_read(ins[24:20]);
        id_ex.alu_op   = ALU_ADD;
        id_ex.wb_sel   = WB_ALU;
        case (opcode)
            OP_LUI: begin
                id_ex.imm       = {ins[31:12], 12'b0};
                id_ex.alu_op    = ALU_PASS_B;
                id_ex.use_imm   = 1'b1;
                id_ex.reg_write = 1'b1;
            end
            OP_IMM, OP_REG: begin
                id_ex.imm       = {{20{ins[31]}}, ins[31:20]};
                id_ex.use_imm   = (opcode == OP_IMM);
                id_ex.reg_write = 1'b1;
                case (funct3)
                    3'b100:  id_ex.alu_op = ALU_XOR;
                    3'b110:  id_ex.alu_op = ALU_OR;
                    3'b111:  id_ex.alu_op = ALU_AND;
                    // SUB only exists in register form
                    default: id_ex.alu_op = (opcode == OP_REG && ins[30]) ? ALU_SUB : ALU_ADD;
                endcase
            end
            OP_LOAD: begin
                id_ex.imm       = {{20{ins[31]}}, ins[31:20]};
                id_ex.use_imm   = 1'b1;
                id_ex.mem_read  = 1'b1;
                id_ex.reg_write = 1'b1;
                id_ex.wb_sel    = WB_MEM;
            end
            OP_STORE: begin
                id_ex.imm       = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                id_ex.use_imm   = 1'b1;
                id_ex.mem_write = 1'b1;
            end
            OP_BRANCH: begin
                id_ex.imm       = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                id_ex.branch    = 1'b1;
                id_ex.branch_ne = funct3[0];
            end
            OP_JAL: begin
                id_ex.imm       = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                id_ex.jal       = 1'b1;
                id_ex.reg_write = 1'b1;
                id_ex.wb_sel    = WB_PC4;
            end
            OP_RTI: id_ex.rti = 1'b1;
            OP_RDI: begin
                id_ex.rdi       = 1'b1;
                id_ex.reg_write = 1'b1;
                id_ex.wb_sel    = WB_RDI;
            end
            // rs1 plus zero goes out on the device port
            OP_SND: begin
                id_ex.snd     = 1'b1;
                id_ex.use_imm = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- hw/fetch.sv
`timescale 1ns/1ns

module fetch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      stall,
    input  logic                      irq_take,
    input  logic                      redirect,
    input  logic [proc_pkg::XLEN-1:0] redirect_pc,
    input  logic                      imem_we,
    input  logic [5:0]                imem_addr,
    input  logic [proc_pkg::XLEN-1:0] imem_wdata,
    output proc_pkg::if_id_t          if_id
);

    import proc_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] imem [IMEM_DEPTH];

    // Program load port, used while reset is held
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_comb begin
        if (irq_take) begin
            pc_next = INT_VECTOR;
        end else if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign if_id.pc    = pc;
    assign if_id.instr = imem[pc[IMEM_AW+1:2]];

endmodule

//--- hw/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // All-zero payload is a bubble, flush wins over stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

//--- hw/proc_pkg.sv
package proc_pkg;

    localparam int XLEN = 32;
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int IMEM_AW = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    // Device buffer slots available at reset
    localparam int SEND_CREDITS = 2;
    localparam int CREDIT_W = $clog2(SEND_CREDITS + 1);

    // Byte address of instruction word 32
    localparam logic [XLEN-1:0] INT_VECTOR = 32'd128;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    // Custom device opcodes
    localparam logic [6:0] OP_RTI    = 7'b0001000;
    localparam logic [6:0] OP_RDI    = 7'b0001010;
    localparam logic [6:0] OP_SND    = 7'b0001011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,
        WB_RDI
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        alu_op_e         alu_op;
        wb_sel_e         wb_sel;
        logic            reg_write;
        logic            mem_read;
        logic            mem_write;
        logic            branch;
        logic            branch_ne;
        logic            jal;
        logic            use_imm;
        logic            snd;
        logic            rdi;
        logic            rti;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] store_data;
        logic [4:0]      rd;
        wb_sel_e         wb_sel;
        logic            reg_write;
        logic            mem_read;
        logic            mem_write;
        logic            snd;
        logic            rdi;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] load_data;
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] rdi_data;
        logic [4:0]      rd;
        wb_sel_e         wb_sel;
        logic            reg_write;
    } mem_wb_t;

    // Result a retiring instruction writes back
    function automatic logic [XLEN-1:0] wb_value(mem_wb_t w);
        case (w.wb_sel)
            WB_MEM:  return w.load_data;
            WB_PC4:  return w.pc4;
            WB_RDI:  return w.rdi_data;
            default: return w.alu_result;
        endcase
    endfunction

endpackage
